//--- Makefile
TOP := tb_aluCluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+rtl
rtl/aluPkg.sv
rtl/aluReqIf.sv
rtl/alu.sv
rtl/aluArbiter.sv
rtl/apbAluPort.sv
rtl/aluCluster.sv
tests/aluChecker.sv
tests/tb_aluCluster.sv

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module alu (
  input  wire aluPkg::aluOp_e           op,
  input  wire [`aluDataWidth-1:0]       operand1,
  input  wire [`aluDataWidth-1:0]       operand2,
  output logic [`aluDataWidth-1:0]      result,
  output logic                          zero
);

  localparam int ShiftWidth = $clog2(`aluDataWidth);

  logic [ShiftWidth-1:0]            shamt;
  logic                             signedLess;
  logic                             unsignedLess;
  logic signed [2*`aluDataWidth-1:0] product;

  assign shamt        = operand2[ShiftWidth-1:0];  // Low bits only
  assign signedLess   = $signed(operand1) < $signed(operand2);
  assign unsignedLess = operand1 < operand2;

  // Both factors signed, so the 64-bit context sign-extends them
  assign product = $signed(operand1) * $signed(operand2);

  always_comb begin
    case (op)
      aluPkg::opAdd:  result = operand1 + operand2;
      aluPkg::opSub:  result = operand1 - operand2;
      aluPkg::opAnd:  result = operand1 & operand2;
      aluPkg::opOr:   result = operand1 | operand2;
      aluPkg::opXor:  result = operand1 ^ operand2;
      aluPkg::opSll:  result = operand1 << shamt;
      aluPkg::opSrl:  result = operand1 >> shamt;
      aluPkg::opSra:  result = $signed(operand1) >>> shamt;  // Sign fill
      aluPkg::opSlt:  result = {{(`aluDataWidth-1){1'b0}}, signedLess};
      aluPkg::opSltu: result = {{(`aluDataWidth-1){1'b0}}, unsignedLess};
      aluPkg::opMin:  result = signedLess ? operand1 : operand2;
      aluPkg::opMax:  result = signedLess ? operand2 : operand1;
      aluPkg::opMinu: result = unsignedLess ? operand1 : operand2;
      aluPkg::opMaxu: result = unsignedLess ? operand2 : operand1;
      aluPkg::opMul:  result = product[`aluDataWidth-1:0];
      aluPkg::opMulh: result = product[2*`aluDataWidth-1:`aluDataWidth];
      default:        result = '0;  // Illegal codes never reach here
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rtl/aluArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module aluArbiter (
  input wire      clk,
  input wire      rstN,
  aluReqIf.server portA,
  aluReqIf.server portB
);

  logic                     prioA;  // Port A wins on contention
  logic                     gntA;
  logic                     gntB;
  aluPkg::aluOp_e           selOp;
  logic [`aluDataWidth-1:0] selOperand1;
  logic [`aluDataWidth-1:0] selOperand2;
  logic [`aluDataWidth-1:0] aluResult;
  logic                     aluZero;

  assign gntA = portA.req && (prioA || !portB.req);
  assign gntB = portB.req && (!prioA || !portA.req);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      prioA <= 1'b1;
    end else if (gntA || gntB) begin
      prioA <= !prioA;  // Flip after every grant
    end
  end

  // Operand mux in front of the single ALU
  assign selOp       = gntB ? portB.op : portA.op;
  assign selOperand1 = gntB ? portB.operand1 : portA.operand1;
  assign selOperand2 = gntB ? portB.operand2 : portA.operand2;

  alu alu_i (
    .op       (selOp),
    .operand1 (selOperand1),
    .operand2 (selOperand2),
    .result   (aluResult),
    .zero     (aluZero)
  );

  // Result goes to both, only the granted port latches it
  assign portA.gnt    = gntA;
  assign portA.result = aluResult;
  assign portA.zero   = aluZero;
  assign portB.gnt    = gntB;
  assign portB.result = aluResult;
  assign portB.zero   = aluZero;

  // A losing port is served on the very next cycle
  loserWaitsOneA: assert property (@(posedge clk) disable iff (!rstN)
    portA.req && !portA.gnt |=> portA.gnt);

  loserWaitsOneB: assert property (@(posedge clk) disable iff (!rstN)
    portB.req && !portB.gnt |=> portB.gnt);

endmodule

`default_nettype wire

//--- rtl/aluCluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module aluCluster (
  input  wire                      clk,
  input  wire                      rstN,
  // APB port A
  input  wire [`aluAddrWidth-1:0]  paddrA,
  input  wire                      pselA,
  input  wire                      penableA,
  input  wire                      pwriteA,
  input  wire [`aluDataWidth-1:0]  pwdataA,
  output wire [`aluDataWidth-1:0]  prdataA,
  output wire                      preadyA,
  output wire                      pslverrA,
  // APB port B
  input  wire [`aluAddrWidth-1:0]  paddrB,
  input  wire                      pselB,
  input  wire                      penableB,
  input  wire                      pwriteB,
  input  wire [`aluDataWidth-1:0]  pwdataB,
  output wire [`aluDataWidth-1:0]  prdataB,
  output wire                      preadyB,
  output wire                      pslverrB
);

  aluReqIf reqA ();
  aluReqIf reqB ();

  apbAluPort portA_i (
    .clk     (clk),
    .rstN    (rstN),
    .paddr   (paddrA),
    .psel    (pselA),
    .penable (penableA),
    .pwrite  (pwriteA),
    .pwdata  (pwdataA),
    .prdata  (prdataA),
    .pready  (preadyA),
    .pslverr (pslverrA),
    .aluReq  (reqA.requester)
  );

  apbAluPort portB_i (
    .clk     (clk),
    .rstN    (rstN),
    .paddr   (paddrB),
    .psel    (pselB),
    .penable (penableB),
    .pwrite  (pwriteB),
    .pwdata  (pwdataB),
    .prdata  (prdataB),
    .pready  (preadyB),
    .pslverr (pslverrB),
    .aluReq  (reqB.requester)
  );

  aluArbiter arbiter_i (
    .clk   (clk),
    .rstN  (rstN),
    .portA (reqA.server),
    .portB (reqB.server)
  );

endmodule

`default_nettype wire

//--- rtl/aluPkg.sv
`default_nettype none

`include "alu_params.svh"

package aluPkg;

  // Codes 16 to 31 are illegal and rejected by the port
  typedef enum logic [`aluOpWidth-1:0] {
    opAdd  = 0,
    opSub  = 1,
    opAnd  = 2,
    opOr   = 3,
    opXor  = 4,
    opSll  = 5,
    opSrl  = 6,
    opSra  = 7,
    opSlt  = 8,  // Signed compare, result 1 or 0
    opSltu = 9,
    opMin  = 10,
    opMax  = 11,
    opMinu = 12,
    opMaxu = 13,
    opMul  = 14, // Low half of product
    opMulh = 15  // Signed high half
  } aluOp_e;

  typedef enum logic [`aluAddrWidth-1:0] {
    regOperand1 = 'h00,
    regOperand2 = 'h04,
    regOpcode   = 'h08, // Write starts an operation
    regResult   = 'h0C, // Read only
    regStatus   = 'h10  // Bit 0 busy, bit 1 zero
  } portReg_e;

endpackage

`default_nettype wire

//--- rtl/aluReqIf.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

interface aluReqIf;

  logic                     req;      // Held until gnt
  aluPkg::aluOp_e           op;
  logic [`aluDataWidth-1:0] operand1;
  logic [`aluDataWidth-1:0] operand2;
  logic                     gnt;      // One cycle, result valid
  logic [`aluDataWidth-1:0] result;
  logic                     zero;

  modport requester (
    output req, op, operand1, operand2,
    input  gnt, result, zero
  );

  modport server (
    input  req, op, operand1, operand2,
    output gnt, result, zero
  );

endinterface

`default_nettype wire

//--- rtl/alu_params.svh
`ifndef aluParamsSvh
`define aluParamsSvh

// Operand and result width
`define aluDataWidth 32

// Opcode field width, covers the 16 legal codes plus the illegal range
`define aluOpWidth 5

// APB byte address width of one port
`define aluAddrWidth 5

`endif

//--- rtl/apbAluPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module apbAluPort (
  input  wire                        clk,
  input  wire                        rstN,
  input  wire [`aluAddrWidth-1:0]    paddr,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire [`aluDataWidth-1:0]    pwdata,
  output logic [`aluDataWidth-1:0]   prdata,
  output logic                       pready,
  output logic                       pslverr,
  aluReqIf.requester                 aluReq
);

  aluPkg::portReg_e         regSel;
  logic                     access;
  logic                     mapped;
  logic                     writeDenied;
  logic                     opLegal;
  logic                     wrOk;
  logic [`aluDataWidth-1:0] operand1Reg;
  logic [`aluDataWidth-1:0] operand2Reg;
  aluPkg::aluOp_e           opcodeReg;
  logic [`aluDataWidth-1:0] resultReg;
  logic                     zeroReg;
  logic                     busy;

  assign regSel = aluPkg::portReg_e'(paddr);
  assign access = psel && penable;
  assign pready = 1'b1;  // No wait states

  // Upper bits must be clear and the code inside the enum range
  assign opLegal = (pwdata[`aluDataWidth-1:`aluOpWidth] == '0) &&
                   (pwdata[`aluOpWidth-1:0] <= aluPkg::opMulh);

  always_comb begin
    mapped      = 1'b1;
    writeDenied = 1'b0;
    case (regSel)
      aluPkg::regOperand1,
      aluPkg::regOperand2: writeDenied = 1'b0;
      aluPkg::regOpcode:   writeDenied = busy || !opLegal;
      aluPkg::regResult,
      aluPkg::regStatus:   writeDenied = 1'b1;  // Read only
      default:             mapped = 1'b0;
    endcase
  end

  assign pslverr = access && (!mapped || (pwrite && writeDenied));
  assign wrOk    = access && pwrite && !pslverr;

  always_comb begin
    case (regSel)
      aluPkg::regOperand1: prdata = operand1Reg;
      aluPkg::regOperand2: prdata = operand2Reg;
      aluPkg::regOpcode:   prdata = {{(`aluDataWidth-`aluOpWidth){1'b0}}, opcodeReg};
      aluPkg::regResult:   prdata = resultReg;
      aluPkg::regStatus:   prdata = {{(`aluDataWidth-2){1'b0}}, zeroReg, busy};
      default:             prdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      operand1Reg <= '0;
      operand2Reg <= '0;
      opcodeReg   <= aluPkg::opAdd;
      resultReg   <= '0;
      zeroReg     <= 1'b0;
      busy        <= 1'b0;
    end else begin
      // Operands stay frozen while a request is pending
      if (wrOk && !busy && regSel == aluPkg::regOperand1) begin
        operand1Reg <= pwdata;
      end
      if (wrOk && !busy && regSel == aluPkg::regOperand2) begin
        operand2Reg <= pwdata;
      end
      if (wrOk && regSel == aluPkg::regOpcode) begin
        opcodeReg <= aluPkg::aluOp_e'(pwdata[`aluOpWidth-1:0]);
        busy      <= 1'b1;  // Request from next cycle
      end else if (aluReq.gnt) begin
        resultReg <= aluReq.result;
        zeroReg   <= aluReq.zero;
        busy      <= 1'b0;
      end
    end
  end

  assign aluReq.req      = busy;
  assign aluReq.op       = opcodeReg;
  assign aluReq.operand1 = operand1Reg;
  assign aluReq.operand2 = operand2Reg;

  reqStable: assert property (@(posedge clk) disable iff (!rstN)
    aluReq.req && !aluReq.gnt |=> aluReq.req && $stable(aluReq.op) &&
      $stable(aluReq.operand1) && $stable(aluReq.operand2));

  // Error only in the access phase that follows a setup phase
  errInAccess: assert property (@(posedge clk) disable iff (!rstN)
    pslverr |-> $past(psel && !penable));

endmodule

`default_nettype wire

//--- tests/aluChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module aluChecker (
  input wire                      clk,
  input wire                      rstN,
  input wire [`aluAddrWidth-1:0]  paddrA,
  input wire                      pselA,
  input wire                      penableA,
  input wire                      pwriteA,
  input wire [`aluDataWidth-1:0]  pwdataA,
  input wire [`aluDataWidth-1:0]  prdataA,
  input wire                      preadyA,
  input wire                      pslverrA,
  input wire [`aluAddrWidth-1:0]  paddrB,
  input wire                      pselB,
  input wire                      penableB,
  input wire                      pwriteB,
  input wire [`aluDataWidth-1:0]  pwdataB,
  input wire [`aluDataWidth-1:0]  prdataB,
  input wire                      preadyB,
  input wire                      pslverrB
);

  int errorCount = 0;
  int checkCount = 0;

  // Expected register contents, index 0 is port A
  logic [`aluDataWidth-1:0] expOperand1 [2];
  logic [`aluDataWidth-1:0] expOperand2 [2];
  logic [`aluOpWidth-1:0]   expOpcode   [2];
  logic [`aluDataWidth-1:0] expResult   [2];
  logic                     expZero     [2];

  function automatic logic [`aluDataWidth-1:0] aluModel(input logic [`aluOpWidth-1:0] op,
      input logic [`aluDataWidth-1:0] a, input logic [`aluDataWidth-1:0] b);
    logic signed [63:0] prod;
    int                 sh;
    prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    sh   = int'(b[4:0]);
    case (op)
      aluPkg::opAdd:  return a + b;
      aluPkg::opSub:  return a - b;
      aluPkg::opAnd:  return a & b;
      aluPkg::opOr:   return a | b;
      aluPkg::opXor:  return a ^ b;
      aluPkg::opSll:  return a << sh;
      aluPkg::opSrl:  return a >> sh;
      aluPkg::opSra:  return $signed(a) >>> sh;
      aluPkg::opSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      aluPkg::opSltu: return (a < b) ? 32'd1 : 32'd0;
      aluPkg::opMin:  return ($signed(a) < $signed(b)) ? a : b;
      aluPkg::opMax:  return ($signed(a) < $signed(b)) ? b : a;
      aluPkg::opMinu: return (a < b) ? a : b;
      aluPkg::opMaxu: return (a < b) ? b : a;
      aluPkg::opMul:  return prod[31:0];
      aluPkg::opMulh: return prod[63:32];
      default:        return '0;
    endcase
  endfunction

  task automatic observe(input int p, input logic [`aluAddrWidth-1:0] addr, input logic wr,
      input logic [`aluDataWidth-1:0] wdata, input logic [`aluDataWidth-1:0] rdata,
      input logic ready, input logic err);
    logic [`aluDataWidth-1:0] exp;
    logic                     doCheck;
    checkCount++;
    if (ready !== 1'b1) begin  // No wait states on either port
      errorCount++;
      $display("[ERROR] pready%s addr 0x%02h expected 0x1 actual 0x%0h",
               (p == 0) ? "A" : "B", addr, ready);
    end
    if (err) return;  // Rejected access changes nothing
    exp     = '0;
    doCheck = 1'b1;
    if (wr) begin
      case (addr)
        aluPkg::regOperand1: expOperand1[p] = wdata;
        aluPkg::regOperand2: expOperand2[p] = wdata;
        aluPkg::regOpcode: begin
          expOpcode[p] = wdata[`aluOpWidth-1:0];
          expResult[p] = aluModel(expOpcode[p], expOperand1[p], expOperand2[p]);
          expZero[p]   = (expResult[p] == '0);
        end
        default: ;
      endcase
    end else begin
      case (addr)
        aluPkg::regOperand1: exp = expOperand1[p];
        aluPkg::regOperand2: exp = expOperand2[p];
        aluPkg::regOpcode:   exp = {{(`aluDataWidth-`aluOpWidth){1'b0}}, expOpcode[p]};
        aluPkg::regResult:   exp = expResult[p];
        aluPkg::regStatus: begin
          if (rdata[0]) doCheck = 1'b0;  // Still busy, nothing settled yet
          exp = {{(`aluDataWidth-2){1'b0}}, expZero[p], 1'b0};
        end
        default: doCheck = 1'b0;
      endcase
      if (doCheck) begin
        checkCount++;
        if (rdata !== exp) begin
          errorCount++;
          $display("[ERROR] prdata%s addr 0x%02h expected 0x%08h actual 0x%08h",
                   (p == 0) ? "A" : "B", addr, exp, rdata);
        end
      end
    end
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      for (int p = 0; p < 2; p++) begin
        expOperand1[p] = '0;
        expOperand2[p] = '0;
        expOpcode[p]   = aluPkg::opAdd;
        expResult[p]   = '0;
        expZero[p]     = 1'b0;
      end
    end else begin
      if (pselA && penableA) observe(0, paddrA, pwriteA, pwdataA, prdataA, preadyA, pslverrA);
      if (pselB && penableB) observe(1, paddrB, pwriteB, pwdataB, prdataB, preadyB, pslverrB);
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_aluCluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_params.svh"

module tb_aluCluster;

  localparam int DirectedOps   = 48;
  localparam int RandomOps     = 40;  // Per port, both ports run in parallel
  localparam int CyclesPerOp   = 30;
  localparam int TimeoutCycles = (DirectedOps + RandomOps + 12) * CyclesPerOp + 1000;

  logic                     clk;
  logic                     rstN;
  logic [`aluAddrWidth-1:0] paddrA;
  logic                     pselA;
  logic                     penableA;
  logic                     pwriteA;
  logic [`aluDataWidth-1:0] pwdataA;
  wire  [`aluDataWidth-1:0] prdataA;
  wire                      preadyA;
  wire                      pslverrA;
  logic [`aluAddrWidth-1:0] paddrB;
  logic                     pselB;
  logic                     penableB;
  logic                     pwriteB;
  logic [`aluDataWidth-1:0] pwdataB;
  wire  [`aluDataWidth-1:0] prdataB;
  wire                      preadyB;
  wire                      pslverrB;

  logic [31:0] lcgState;
  int          cycles = 0;
  int          respErrors;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  aluCluster dut_i (.*);

  aluChecker chk_i (
    .clk(clk), .rstN(rstN),
    .paddrA(paddrA), .pselA(pselA), .penableA(penableA), .pwriteA(pwriteA),
    .pwdataA(pwdataA), .prdataA(prdataA), .preadyA(preadyA), .pslverrA(pslverrA),
    .paddrB(paddrB), .pselB(pselB), .penableB(penableB), .pwriteB(pwriteB),
    .pwdataB(pwdataB), .prdataB(prdataB), .preadyB(preadyB), .pslverrB(pslverrB)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic driveBus(input int port, input logic sel, input logic en, input logic wr,
      input logic [`aluAddrWidth-1:0] addr, input logic [`aluDataWidth-1:0] data);
    if (port == 0) begin
      pselA <= sel;
      penableA <= en;
      pwriteA <= wr;
      paddrA <= addr;
      pwdataA <= data;
    end else begin
      pselB <= sel;
      penableB <= en;
      pwriteB <= wr;
      paddrB <= addr;
      pwdataB <= data;
    end
  endtask

  // Starts on a rising edge and ends on one, so accesses run back to back
  task automatic apbAccess(input int port, input logic wr, input logic [`aluAddrWidth-1:0] addr,
      input logic [`aluDataWidth-1:0] wdata, output logic [`aluDataWidth-1:0] rdata,
      output logic err, input logic expErr);
    driveBus(port, 1'b1, 1'b0, wr, addr, wdata);
    @(posedge clk);
    driveBus(port, 1'b1, 1'b1, wr, addr, wdata);
    @(negedge clk);
    rdata = (port == 0) ? prdataA : prdataB;
    err   = (port == 0) ? pslverrA : pslverrB;
    @(posedge clk);
    driveBus(port, 1'b0, 1'b0, 1'b0, addr, wdata);
    if (err !== expErr) begin
      respErrors++;
      $display("[ERROR] pslverr%s addr 0x%02h expected 0x%0h actual 0x%0h",
               (port == 0) ? "A" : "B", addr, expErr, err);
    end
  endtask

  task automatic apbWrite(input int port, input logic [`aluAddrWidth-1:0] addr,
      input logic [`aluDataWidth-1:0] data, input logic expErr);
    logic [`aluDataWidth-1:0] rd;
    logic                     err;
    apbAccess(port, 1'b1, addr, data, rd, err, expErr);
  endtask

  task automatic apbRead(input int port, input logic [`aluAddrWidth-1:0] addr,
      output logic [`aluDataWidth-1:0] data, input logic expErr);
    logic err;
    apbAccess(port, 1'b0, addr, '0, data, err, expErr);
  endtask

  task automatic waitIdle(input int port);
    logic [`aluDataWidth-1:0] st;
    st = 1;
    while (st[0]) apbRead(port, aluPkg::regStatus, st, 1'b0);
  endtask

  task automatic runOp(input int port, input logic [`aluOpWidth-1:0] op,
      input logic [`aluDataWidth-1:0] a, input logic [`aluDataWidth-1:0] b);
    logic [`aluDataWidth-1:0] rd;
    apbWrite(port, aluPkg::regOperand1, a, 1'b0);
    apbWrite(port, aluPkg::regOperand2, b, 1'b0);
    apbWrite(port, aluPkg::regOpcode, {27'd0, op}, 1'b0);
    waitIdle(port);
    apbRead(port, aluPkg::regResult, rd, 1'b0);  // Checker compares the value
  endtask

  initial begin
    logic [`aluDataWidth-1:0] rd;
    logic [`aluDataWidth-1:0] cornerA [3];
    logic [`aluDataWidth-1:0] cornerB [3];
    logic [`aluOpWidth-1:0]   opA;
    logic [`aluOpWidth-1:0]   opB;
    logic [`aluDataWidth-1:0] a1;
    logic [`aluDataWidth-1:0] a2;
    logic [`aluDataWidth-1:0] b1;
    logic [`aluDataWidth-1:0] b2;
    int                       total;

    lcgState   = 32'd1791;
    respErrors = 0;
    rstN     <= 1'b0;
    paddrA   <= '0;
    pselA    <= 1'b0;
    penableA <= 1'b0;
    pwriteA  <= 1'b0;
    pwdataA  <= '0;
    paddrB   <= '0;
    pselB    <= 1'b0;
    penableB <= 1'b0;
    pwriteB  <= 1'b0;
    pwdataB  <= '0;
    cornerA = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000};
    cornerB = '{32'hFFFF_FFFF, 32'h0000_003F, 32'h8000_0000};  // 0x3F shifts by 31

    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);

    // Reset values on both ports
    for (int p = 0; p < 2; p++) begin
      apbRead(p, aluPkg::regOperand1, rd, 1'b0);
      apbRead(p, aluPkg::regOperand2, rd, 1'b0);
      apbRead(p, aluPkg::regOpcode, rd, 1'b0);
      apbRead(p, aluPkg::regResult, rd, 1'b0);
      apbRead(p, aluPkg::regStatus, rd, 1'b0);
    end

    // Every opcode with corner operands on port A
    for (int op = 0; op < 16; op++) begin
      for (int c = 0; c < 3; c++) runOp(0, op[4:0], cornerA[c], cornerB[c]);
    end

    // Both ports at once, contention on every opcode write
    for (int i = 0; i < RandomOps; i++) begin
      opA = {1'b0, 4'(nextRand() >> 28)};
      a1  = nextRand();
      b1  = nextRand();
      opB = {1'b0, 4'(nextRand() >> 28)};
      a2  = nextRand();
      b2  = nextRand();
      fork
        runOp(0, opA, a1, b1);
        runOp(1, opB, a2, b2);
      join
    end

    // Even grant count so far, so port A wins and port B stays busy
    apbWrite(1, aluPkg::regOperand1, 32'd5, 1'b0);
    apbWrite(1, aluPkg::regOperand2, 32'd3, 1'b0);
    fork
      apbWrite(0, aluPkg::regOpcode, {27'd0, aluPkg::opAdd}, 1'b0);
      apbWrite(1, aluPkg::regOpcode, {27'd0, aluPkg::opAdd}, 1'b0);
    join
    apbWrite(1, aluPkg::regOpcode, {27'd0, aluPkg::opSub}, 1'b1);  // Pending ADD survives
    waitIdle(0);
    waitIdle(1);
    apbRead(1, aluPkg::regResult, rd, 1'b0);

    apbWrite(0, aluPkg::regOpcode, 32'h0000_0010, 1'b1);  // First illegal code
    apbWrite(1, aluPkg::regOpcode, 32'h0000_0100, 1'b1);
    apbRead(0, 5'h14, rd, 1'b1);
    apbWrite(1, 5'h1C, 32'h1234, 1'b1);
    apbWrite(0, aluPkg::regResult, 32'h1234, 1'b1);
    apbWrite(1, aluPkg::regStatus, 32'h3, 1'b1);

    // Zero flag set by equal SUB, then cleared
    runOp(1, aluPkg::opSub, 32'd1234, 32'd1234);
    apbRead(1, aluPkg::regStatus, rd, 1'b0);
    runOp(1, aluPkg::opAdd, 32'd1, 32'd1);
    apbRead(1, aluPkg::regStatus, rd, 1'b0);

    @(posedge clk);
    total = chk_i.errorCount + respErrors;
    $display("Checks %0d, data errors %0d, response errors %0d",
             chk_i.checkCount, chk_i.errorCount, respErrors);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
